//--- rtl/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// data, pc and memory address width
`define WB_XLEN 64

// integer register file depth
`define WB_NREG 32

// width of a register index
`define WB_REGIDX_W 5

// instruction word width
`define WB_INST_W 32

// load and store counters, instret is always WB_XLEN wide
`define WB_CNT_W 32

`endif

//--- rtl/wb_pkg.sv
`include "wb_config.svh"

package wb_pkg;

	// plain vectors for the widths that carry a meaning
	typedef logic [`WB_XLEN-1:0] xlen_t;
	typedef logic [`WB_INST_W-1:0] inst_t;
	typedef logic [`WB_REGIDX_W-1:0] reg_idx_t;
	typedef logic [`WB_CNT_W-1:0] cnt_t;

	// one instruction leaving the MEM stage
	typedef struct packed {
		xlen_t pc;
		inst_t inst;
		reg_idx_t rd;
		// instruction writes rd
		logic wen;
		xlen_t wdata;
		// load address
		xlen_t raddr;
		// store address
		xlen_t waddr;
	} mem_entry_t;

	// bundle for the hazard logic upstream
	typedef struct packed {
		// valid entry in WB that will write a nonzero rd
		logic writing;
		reg_idx_t rd;
		xlen_t wdata;
	} gpr_fwd_t;

	// memory access class of a retired instruction
	typedef enum logic [1:0] {
		ACC_NONE = 2'd0,
		ACC_LOAD = 2'd1,
		ACC_STORE = 2'd2
	} access_kind_e;

	// one retirement as reported by the monitor
	typedef struct packed {
		xlen_t pc;
		inst_t inst;
		access_kind_e kind;
		// raddr for loads, waddr for stores, else zero
		xlen_t addr;
	} retire_event_t;

endpackage

//--- rtl/wb_stage_reg.sv
module wb_stage_reg import wb_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic mem_valid,
	input mem_entry_t mem_entry,
	output logic wb_valid,
	output mem_entry_t wb_entry,
	output logic retire,
	output logic gpr_we,
	output gpr_fwd_t fwd
);

	logic fwd_rd_nonzero;

	// valid bit of the held entry
	// a stall freezes it, otherwise it follows the MEM stage
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else if (!stall) begin
			wb_valid <= mem_valid;
		end
	end

	// payload of the held entry
	// only meaningful while wb_valid is set
	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_entry <= mem_entry;
		end
	end

	// the entry leaves WB on the first unstalled edge,
	// so this fires exactly once per instruction
	always_comb begin
		retire = wb_valid && !stall;
	end

	// register file write, x0 is filtered inside the file
	always_comb begin
		gpr_we = retire && wb_entry.wen;
	end

	// x0 never produces a forward
	always_comb begin
		fwd_rd_nonzero = (wb_entry.rd != '0);
	end

	// forward bundle follows the held entry, stalled or not
	always_comb begin
		fwd.writing = wb_valid && wb_entry.wen && fwd_rd_nonzero;
		fwd.rd = wb_entry.rd;
		fwd.wdata = wb_entry.wdata;
	end

endmodule

//--- rtl/gpr_file.sv
`include "wb_config.svh"

module gpr_file import wb_pkg::*; (
	input logic clk,
	input logic rst,
	input logic we,
	input reg_idx_t waddr,
	input xlen_t wdata,
	input reg_idx_t raddr_a,
	input reg_idx_t raddr_b,
	output xlen_t rdata_a,
	output xlen_t rdata_b
);

	// integer register array, entry 0 is x0
	xlen_t regs [`WB_NREG];

	logic write_hit;

	// writes to x0 are dropped so it stays zero after reset
	always_comb begin
		write_hit = we && (waddr != '0);
	end

	// single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `WB_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (write_hit) begin
			regs[waddr] <= wdata;
		end
	end

	// two asynchronous read ports
	// no bypass from the write port, a write shows up one cycle later
	always_comb begin
		rdata_a = regs[raddr_a];
	end

	always_comb begin
		rdata_b = regs[raddr_b];
	end

endmodule

//--- rtl/retire_monitor.sv
module retire_monitor import wb_pkg::*; (
	input logic clk,
	input logic rst,
	input logic retire,
	input mem_entry_t entry,
	output logic retire_valid,
	output retire_event_t retire_event,
	output xlen_t instret,
	output cnt_t load_count,
	output cnt_t store_count
);

	// RV64I major opcodes for memory access
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	access_kind_e kind;
	xlen_t addr;
	retire_event_t event_next;

	// instruction fields
	always_comb begin
		opcode = entry.inst[6:0];
		funct3 = entry.inst[14:12];
	end

	// loads: lb lh lw ld lbu lhu lwu (funct3 0..6)
	// stores: sb sh sw sd (funct3 0..3)
	// undefined funct3 on either opcode is reported as no access
	always_comb begin
		case (opcode)
			OPC_LOAD: begin
				if (funct3 != 3'b111) begin
					kind = ACC_LOAD;
				end else begin
					kind = ACC_NONE;
				end
			end
			OPC_STORE: begin
				if (!funct3[2]) begin
					kind = ACC_STORE;
				end else begin
					kind = ACC_NONE;
				end
			end
			default: begin
				kind = ACC_NONE;
			end
		endcase
	end

	// pick the address that matches the access
	always_comb begin
		case (kind)
			ACC_LOAD: addr = entry.raddr;
			ACC_STORE: addr = entry.waddr;
			default: addr = '0;
		endcase
	end

	always_comb begin
		event_next.pc = entry.pc;
		event_next.inst = entry.inst;
		event_next.kind = kind;
		event_next.addr = addr;
	end

	// one-cycle event pulse, one cycle behind the retire strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= retire;
		end
	end

	// event payload only loads on a retirement
	always_ff @(posedge clk) begin
		if (retire) begin
			retire_event <= event_next;
		end
	end

	// retirement counters, updated on the same edge as the event
	always_ff @(posedge clk) begin
		if (rst) begin
			instret <= '0;
			load_count <= '0;
			store_count <= '0;
		end else if (retire) begin
			instret <= instret + xlen_t'(1);
			if (kind == ACC_LOAD) begin
				load_count <= load_count + cnt_t'(1);
			end
			if (kind == ACC_STORE) begin
				store_count <= store_count + cnt_t'(1);
			end
		end
	end

endmodule

//--- rtl/wb_subsystem_top.sv
module wb_subsystem_top import wb_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic mem_valid,
	input mem_entry_t mem_entry,
	input reg_idx_t raddr_a,
	input reg_idx_t raddr_b,
	output xlen_t rdata_a,
	output xlen_t rdata_b,
	output gpr_fwd_t fwd,
	output logic retire_valid,
	output retire_event_t retire_event,
	output xlen_t instret,
	output cnt_t load_count,
	output cnt_t store_count
);

	mem_entry_t wb_entry;
	logic retire;
	logic gpr_we;

	// MEM/WB register
	// the held valid bit is visible outside only through retire and fwd
	wb_stage_reg wb_stage_reg_i (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.mem_valid(mem_valid),
		.mem_entry(mem_entry),
		.wb_valid(),
		.wb_entry(wb_entry),
		.retire(retire),
		.gpr_we(gpr_we),
		.fwd(fwd)
	);

	// integer register file, written by the retiring entry
	gpr_file gpr_file_i (
		.clk(clk),
		.rst(rst),
		.we(gpr_we),
		.waddr(wb_entry.rd),
		.wdata(wb_entry.wdata),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	// retire events and counters
	retire_monitor retire_monitor_i (
		.clk(clk),
		.rst(rst),
		.retire(retire),
		.entry(wb_entry),
		.retire_valid(retire_valid),
		.retire_event(retire_event),
		.instret(instret),
		.load_count(load_count),
		.store_count(store_count)
	);

endmodule

//--- test/wb_subsystem_tb.sv
`include "wb_config.svh"

module wb_subsystem_tb import wb_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int SWEEP_CYCLES = `WB_NREG;
	localparam int STIM_CYCLES = 400;
	localparam int DRAIN_CYCLES = 8;
	localparam int TOTAL_CYCLES = STIM_CYCLES + DRAIN_CYCLES + 2 * SWEEP_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h2d1c1b17;

	logic clk;
	logic rst;
	logic stall;
	logic mem_valid;
	mem_entry_t mem_entry;
	reg_idx_t raddr_a;
	reg_idx_t raddr_b;
	xlen_t rdata_a;
	xlen_t rdata_b;
	gpr_fwd_t fwd;
	logic retire_valid;
	retire_event_t retire_event;
	xlen_t instret;
	cnt_t load_count;
	cnt_t store_count;

	// inputs as seen by the DUT at the next edge
	logic applied_valid;
	logic applied_stall;
	mem_entry_t applied_entry;

	// reference model state
	logic m_valid;
	mem_entry_t m_entry;
	xlen_t m_regs [`WB_NREG];
	retire_event_t exp_events [$];
	xlen_t m_instret;
	cnt_t m_loads;
	cnt_t m_stores;
	int accepted_count;
	int x0_writes;

	logic [31:0] rng_state;
	int error_count;
	int cycle_count;
	int n;
	logic [31:0] r;
	mem_entry_t e;

	wb_subsystem_top wb_subsystem_top_i (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.mem_valid(mem_valid),
		.mem_entry(mem_entry),
		.raddr_a(raddr_a),
		.raddr_b(raddr_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.fwd(fwd),
		.retire_valid(retire_valid),
		.retire_event(retire_event),
		.instret(instret),
		.load_count(load_count),
		.store_count(store_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
			input string what);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED at %0d ns: %s: got %0h, expected %0h",
				$time, what, actual, expected));
		end
	endtask

	// guards against a hung DUT or a stuck stimulus loop
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	// xorshift32
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic logic [6:0] alu_opcode(input logic [2:0] sel);
		case (sel)
			3'd0: return 7'b0010011;
			3'd1: return 7'b0110011;
			3'd2: return 7'b0011011;
			3'd3: return 7'b0111011;
			3'd4: return 7'b0110111;
			3'd5: return 7'b0010111;
			default: return 7'b1101111;
		endcase
	endfunction

	// RV64I has 7 load widths and 4 store widths
	function automatic access_kind_e expected_kind(input inst_t inst);
		logic [6:0] opc;
		logic [2:0] f3;
		opc = inst[6:0];
		f3 = inst[14:12];
		if (opc == 7'b0000011 && f3 <= 3'd6) begin
			return ACC_LOAD;
		end else if (opc == 7'b0100011 && f3 <= 3'd3) begin
			return ACC_STORE;
		end
		return ACC_NONE;
	endfunction

	function automatic gpr_fwd_t expected_fwd();
		gpr_fwd_t f;
		f.writing = m_valid && m_entry.wen && (m_entry.rd != 5'd0);
		f.rd = m_entry.rd;
		f.wdata = m_entry.wdata;
		return f;
	endfunction

	task automatic make_entry(output mem_entry_t ent);
		logic [31:0] sel;
		logic [31:0] bits;
		logic [6:0] opc;
		sel = next_random();
		bits = next_random();
		case (sel[5:4])
			2'd0: opc = 7'b0000011;
			2'd1: opc = 7'b0100011;
			default: opc = alu_opcode(sel[10:8]);
		endcase
		ent.inst = {bits[31:15], sel[2:0], bits[11:7], opc};
		ent.rd = sel[20:16];
		// x0 targets show up more often than 1 in 32
		if (sel[23:21] == 3'd0) begin
			ent.rd = 5'd0;
		end
		ent.wen = sel[24] | sel[25];
		ent.pc = {next_random(), next_random()};
		ent.wdata = {next_random(), next_random()};
		ent.raddr = {next_random(), next_random()};
		ent.waddr = {next_random(), next_random()};
	endtask

	// one clock edge of the reference model
	task automatic model_edge();
		retire_event_t ev;
		if (m_valid && !applied_stall) begin
			ev.pc = m_entry.pc;
			ev.inst = m_entry.inst;
			ev.kind = expected_kind(m_entry.inst);
			if (ev.kind == ACC_LOAD) begin
				ev.addr = m_entry.raddr;
			end else if (ev.kind == ACC_STORE) begin
				ev.addr = m_entry.waddr;
			end else begin
				ev.addr = '0;
			end
			exp_events.push_back(ev);
			m_instret++;
			if (ev.kind == ACC_LOAD) begin
				m_loads++;
			end
			if (ev.kind == ACC_STORE) begin
				m_stores++;
			end
			if (m_entry.wen && m_entry.rd == 5'd0) begin
				x0_writes++;
			end else if (m_entry.wen) begin
				m_regs[m_entry.rd] = m_entry.wdata;
			end
		end
		if (!applied_stall) begin
			m_valid = applied_valid;
			m_entry = applied_entry;
			if (applied_valid) begin
				accepted_count++;
			end
		end
	endtask

	task automatic check_outputs();
		retire_event_t ev;
		check_value(retire_valid, exp_events.size() != 0, "retire_valid");
		if (retire_valid) begin
			ev = exp_events.pop_front();
			check_value(retire_event.pc, ev.pc, "retire_event.pc");
			check_value(retire_event.inst, ev.inst, "retire_event.inst");
			check_value(retire_event.kind, ev.kind, "retire_event.kind");
			check_value(retire_event.addr, ev.addr, "retire_event.addr");
		end
		check_value(fwd, expected_fwd(), "fwd");
		check_value(instret, m_instret, "instret");
		check_value(load_count, m_loads, "load_count");
		check_value(store_count, m_stores, "store_count");
	endtask

	task automatic run_cycle(input logic valid_in, input logic stall_in,
			input mem_entry_t entry_in, input reg_idx_t ra_in, input reg_idx_t rb_in);
		@(posedge clk);
		#2;
		model_edge();
		check_outputs();
		mem_valid = valid_in;
		stall = stall_in;
		mem_entry = entry_in;
		raddr_a = ra_in;
		raddr_b = rb_in;
		applied_valid = valid_in;
		applied_stall = stall_in;
		applied_entry = entry_in;
		// read ports settle well before the falling edge
		@(negedge clk);
		check_value(rdata_a, m_regs[ra_in], $sformatf("rdata_a x%0d", ra_in));
		check_value(rdata_b, m_regs[rb_in], $sformatf("rdata_b x%0d", rb_in));
	endtask

	task automatic sweep_registers();
		for (int i = 0; i < SWEEP_CYCLES; i++) begin
			run_cycle(1'b0, 1'b0, '0, reg_idx_t'(i), reg_idx_t'(SWEEP_CYCLES - 1 - i));
		end
	endtask

	initial begin
		rst = 1'b1;
		stall = 1'b0;
		// a writing entry is offered all through reset and must not be held
		mem_valid = 1'b1;
		mem_entry = '0;
		mem_entry.rd = 5'd1;
		mem_entry.wen = 1'b1;
		mem_entry.wdata = '1;
		raddr_a = '0;
		raddr_b = '0;
		applied_valid = 1'b0;
		applied_stall = 1'b0;
		applied_entry = '0;
		m_valid = 1'b0;
		m_entry = '0;
		for (int i = 0; i < `WB_NREG; i++) begin
			m_regs[i] = '0;
		end
		m_instret = '0;
		m_loads = '0;
		m_stores = '0;
		accepted_count = 0;
		x0_writes = 0;
		rng_state = SEED;
		error_count = 0;
		cycle_count = 0;

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		mem_valid = 1'b0;
		mem_entry = '0;

		// state right after reset
		check_value(retire_valid, 1'b0, "retire_valid after reset");
		check_value(fwd.writing, 1'b0, "fwd.writing after reset");
		check_value(instret, '0, "instret after reset");
		check_value(load_count, '0, "load_count after reset");
		check_value(store_count, '0, "store_count after reset");
		sweep_registers();

		// random traffic with stalls and reads on random indices
		for (n = 0; n < STIM_CYCLES; n++) begin
			r = next_random();
			make_entry(e);
			run_cycle(r[1:0] != 2'd0, r[3:2] == 2'd0, e, r[12:8], r[20:16]);
		end

		// let the last entry retire and its event come out
		repeat (DRAIN_CYCLES) run_cycle(1'b0, 1'b0, '0, '0, '0);

		// full register file against the model
		sweep_registers();

		check_value(instret, accepted_count, "one event per accepted entry");
		check_value(instret, m_instret, "final instret");
		check_value(load_count, m_loads, "final load_count");
		check_value(store_count, m_stores, "final store_count");
		if (x0_writes == 0) begin
			abort_run("no write to x0 was exercised by the random traffic");
		end

		if (error_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors were found");
		end
	end

endmodule

//--- filelist.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_stage_reg.sv
rtl/gpr_file.sv
rtl/retire_monitor.sv
rtl/wb_subsystem_top.sv
test/wb_subsystem_tb.sv

//--- Bender.yml
package:
  name: wb_subsystem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wb_pkg.sv
      - rtl/wb_stage_reg.sv
      - rtl/gpr_file.sv
      - rtl/retire_monitor.sv
      - rtl/wb_subsystem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/wb_subsystem_tb.sv
